//--- src/ac97_pkg.sv
package ac97_pkg;

	// Frame geometry
	localparam int frame_bits     = 256;
	localparam int bit_idx_w      = 8;  // Position within a frame
	localparam int slot_w         = 20;
	localparam int tag_w          = 16;
	localparam int sync_high_bits = 15; // Sync window spans the tag slot

	// Mixer sizing
	localparam int level_w = 4; // Also the width of volume_shift
	localparam int n_chan  = 3;

	// Codec register addresses
	localparam logic [6:0] reg_reset      = 7'h00;
	localparam logic [6:0] reg_master_vol = 7'h02;
	localparam logic [6:0] reg_pcm_vol    = 7'h18;
	localparam logic [6:0] reg_power      = 7'h26; // Powerdown control and status
	localparam logic [6:0] reg_vid0       = 7'h7c; // Vendor ID 1
	localparam logic [6:0] reg_vid1       = 7'h7e; // Vendor ID 2

	// Volume register values
	localparam logic [15:0] vol_full = 16'h0000; // Unmuted at full volume
	localparam logic [15:0] vol_0db  = 16'h0808; // Unmuted at 0 dB

	// Slot 1 command address word
	typedef struct packed {
		logic       rd;   // 1 for a register read
		logic [6:0] addr; // Codec register index
		logic [11:0] rsvd; // Slot request bits, always zero here
	} codec_cmd_t;

	// FSM fills in fields while the serializer only sees bits
	typedef union packed {
		logic [slot_w-1:0] raw;
		codec_cmd_t        cmd;
	} codec_slot_u;

	// Bring-up sequence
	typedef enum logic [2:0] {
		s_reset,
		s_master,
		s_pcm,
		s_power,
		s_vid0,
		s_vid1
	} init_state_e;

	// Channel i+1 sits at bits [i*level_w +: level_w]
	typedef struct packed {
		logic [level_w-1:0] ch3;
		logic [level_w-1:0] ch2;
		logic [level_w-1:0] ch1;
	} chan_levels_t;

	// Mask bit i enables channel i+1
	typedef struct packed {
		logic              master;     // Global sound enable
		logic [n_chan-1:0] left_mask;  // Channels routed to slot 3
		logic [n_chan-1:0] right_mask; // Channels routed to slot 4
	} mix_ctrl_t;

	// Payload of slots 1 to 4, all always valid
	typedef struct packed {
		codec_slot_u       cmd;      // Slot 1 command address
		logic [slot_w-1:0] cmd_data; // Slot 2 command data
		logic [slot_w-1:0] left;     // Slot 3 PCM left
		logic [slot_w-1:0] right;    // Slot 4 PCM right
	} out_slots_t;

endpackage

//--- src/link_bit_counter.sv
`timescale 1ns/1ns

module link_bit_counter (
	input  logic                             ac97_bitclk,
	input  logic                             rst,
	output logic [ac97_pkg::bit_idx_w-1:0]   bit_index,
	output logic                             frame_start,
	output logic                             ac97_sync,
	output logic                             ac97_reset_b
);

	logic last_bit; // Final bit of slot 12
	logic in_tag;   // Inside the sync high window

	// Free running bit position, wraps every frame
	always_ff @(posedge ac97_bitclk) begin
		if (rst) begin
			bit_index <= '0;
		end else begin
			bit_index <= bit_index + 1'b1;
		end
	end

	// Codec reset release, one cycle behind rst
	always_ff @(posedge ac97_bitclk) begin
		if (rst) begin
			ac97_reset_b <= 1'b0;
		end else begin
			ac97_reset_b <= 1'b1;
		end
	end

	assign last_bit = bit_index == ac97_pkg::bit_idx_w'(ac97_pkg::frame_bits - 1);
	assign in_tag   = bit_index < ac97_pkg::bit_idx_w'(ac97_pkg::sync_high_bits);

	// Sync rises during the last bit of a frame
	assign ac97_sync = !rst && (last_bit || in_tag);

	// Also fires right after reset since the counter sits at 0
	assign frame_start = !rst && (bit_index == '0);

endmodule

//--- src/codec_init_fsm.sv
`timescale 1ns/1ns

module codec_init_fsm (
	input  logic                          ac97_bitclk,
	input  logic                          rst,
	input  logic                          frame_start,
	output ac97_pkg::codec_slot_u         cmd,
	output logic [ac97_pkg::slot_w-1:0]   cmd_data
);

	ac97_pkg::init_state_e state;
	ac97_pkg::init_state_e next_state;
	logic [15:0]           reg_data; // Register value for writes

	// One step per frame
	always_ff @(posedge ac97_bitclk) begin
		if (rst) begin
			state <= ac97_pkg::s_reset;
		end else if (frame_start) begin
			state <= next_state;
		end
	end

	// Writes run once then the three reads loop
	always_comb begin
		case (state)
			ac97_pkg::s_reset:  next_state = ac97_pkg::s_master;
			ac97_pkg::s_master: next_state = ac97_pkg::s_pcm;
			ac97_pkg::s_pcm:    next_state = ac97_pkg::s_power;
			ac97_pkg::s_power:  next_state = ac97_pkg::s_vid0;
			ac97_pkg::s_vid0:   next_state = ac97_pkg::s_vid1;
			ac97_pkg::s_vid1:   next_state = ac97_pkg::s_power; // Status poll loop
			default:            next_state = ac97_pkg::s_reset;
		endcase
	end

	// Command word per state
	always_comb begin
		cmd          = '0; // Reserved bits stay low
		reg_data     = 16'h0000;
		cmd.cmd.rd   = 1'b1;
		cmd.cmd.addr = ac97_pkg::reg_power;
		case (state)
			ac97_pkg::s_reset: begin
				cmd.cmd.rd   = 1'b0;
				cmd.cmd.addr = ac97_pkg::reg_reset; // Any write resets the codec
			end
			ac97_pkg::s_master: begin
				cmd.cmd.rd   = 1'b0;
				cmd.cmd.addr = ac97_pkg::reg_master_vol;
				reg_data     = ac97_pkg::vol_full;
			end
			ac97_pkg::s_pcm: begin
				cmd.cmd.rd   = 1'b0;
				cmd.cmd.addr = ac97_pkg::reg_pcm_vol;
				reg_data     = ac97_pkg::vol_0db;
			end
			ac97_pkg::s_vid0: begin
				cmd.cmd.addr = ac97_pkg::reg_vid0;
			end
			ac97_pkg::s_vid1: begin
				cmd.cmd.addr = ac97_pkg::reg_vid1;
			end
			default: begin
				cmd.cmd.addr = ac97_pkg::reg_power; // s_power read
			end
		endcase
	end

	// Data is left aligned in slot 2
	assign cmd_data = {reg_data, 4'h0};

endmodule

//--- src/channel_mixer.sv
`timescale 1ns/1ns

module channel_mixer (
	input  ac97_pkg::chan_levels_t                levels,
	input  logic [ac97_pkg::n_chan-1:0]           chan_mask,
	input  logic                                  master,
	input  logic [ac97_pkg::level_w-1:0]          volume_shift,
	output logic [ac97_pkg::slot_w-1:0]           sample
);

	logic [ac97_pkg::n_chan-1:0]  active;    // Enabled and not silent
	logic [1:0]                   n_active;  // Active channel count
	logic [ac97_pkg::level_w-1:0] single;    // Level of the lone active channel
	logic [ac97_pkg::level_w+1:0] half_sum;  // Sum of halved active levels
	logic [ac97_pkg::level_w+1:0] mix_sum;   // Before volume scaling

	// Per channel activity
	genvar g;
	generate
		for (g = 0; g < ac97_pkg::n_chan; g++) begin : g_act
			assign active[g] = chan_mask[g] &&
				(levels[g*ac97_pkg::level_w +: ac97_pkg::level_w] != '0);
		end
	endgenerate

	// Count and accumulate active channels
	always_comb begin
		n_active = '0;
		single   = '0;
		half_sum = '0;
		for (int i = 0; i < ac97_pkg::n_chan; i++) begin
			if (active[i]) begin
				n_active = n_active + 1'b1;
				single   = levels[i*ac97_pkg::level_w +: ac97_pkg::level_w];
				// Halve each level before adding
				half_sum = half_sum + (ac97_pkg::level_w + 2)'(single >> 1);
			end
		end
	end

	// Mute, pass-through or averaged mix
	always_comb begin
		if (!master || n_active == '0) begin
			mix_sum = '0;
		end else if (n_active == 2'd1) begin
			mix_sum = (ac97_pkg::level_w + 2)'(single); // No halving for one channel
		end else begin
			mix_sum = half_sum;
		end
	end

	// Volume as a left shift, high bits fall off
	assign sample = ac97_pkg::slot_w'(mix_sum) << volume_shift;

endmodule

//--- src/frame_serializer.sv
`timescale 1ns/1ns

module frame_serializer (
	input  logic                            ac97_bitclk,
	input  logic                            rst,
	input  logic [ac97_pkg::bit_idx_w-1:0]  bit_index,
	input  logic                            frame_start,
	input  ac97_pkg::out_slots_t            slots,
	output logic                            ac97_sdata_out
);

	// Width of slots 5 to 12
	localparam int unused_w = ac97_pkg::frame_bits - ac97_pkg::tag_w - 4 * ac97_pkg::slot_w;

	ac97_pkg::out_slots_t           slots_q; // Payload held for the whole frame
	logic [ac97_pkg::tag_w-1:0]     tag;
	logic [0:ac97_pkg::frame_bits-1] frame;  // Index 0 goes out first

	// Capture while bit 0 is on the line
	always_ff @(posedge ac97_bitclk) begin
		if (frame_start) begin
			slots_q <= slots;
		end
	end

	// Frame valid plus slots 1 to 4 valid
	assign tag = {1'b1, 4'b1111, (ac97_pkg::tag_w - 5)'(0)};

	// Tag then slots, each MSB first
	assign frame = {
		tag,
		slots_q.cmd.raw,   // Slot 1
		slots_q.cmd_data,  // Slot 2
		slots_q.left,      // Slot 3
		slots_q.right,     // Slot 4
		{unused_w{1'b0}}   // Slots 5 to 12 idle
	};

	// Quiet line while the link is held in reset
	assign ac97_sdata_out = !rst && frame[bit_index];

endmodule

//--- src/ac97_top.sv
`timescale 1ns/1ns

module ac97_top (
	input  logic                               ac97_bitclk,
	input  logic                               rst,
	input  ac97_pkg::chan_levels_t             levels,
	input  ac97_pkg::mix_ctrl_t                mix_ctrl,
	input  logic [ac97_pkg::level_w-1:0]       volume_shift,
	output logic                               ac97_sdata_out,
	output logic                               ac97_sync,
	output logic                               ac97_reset_b,
	output logic                               ac97_strobe
);

	logic [ac97_pkg::bit_idx_w-1:0] bit_index;
	logic                           frame_start;
	ac97_pkg::codec_slot_u          cmd;       // Slot 1 from the FSM
	logic [ac97_pkg::slot_w-1:0]    cmd_data;  // Slot 2 from the FSM
	logic [ac97_pkg::slot_w-1:0]    left;
	logic [ac97_pkg::slot_w-1:0]    right;
	ac97_pkg::out_slots_t           slots;

	link_bit_counter u_counter (
		.ac97_bitclk  (ac97_bitclk),
		.rst          (rst),
		.bit_index    (bit_index),
		.frame_start  (frame_start),
		.ac97_sync    (ac97_sync),
		.ac97_reset_b (ac97_reset_b)
	);

	codec_init_fsm u_init (
		.ac97_bitclk (ac97_bitclk),
		.rst         (rst),
		.frame_start (frame_start),
		.cmd         (cmd),
		.cmd_data    (cmd_data)
	);

	// Left and right share levels but use separate masks
	channel_mixer u_mix_left (
		.levels       (levels),
		.chan_mask    (mix_ctrl.left_mask),
		.master       (mix_ctrl.master),
		.volume_shift (volume_shift),
		.sample       (left)
	);

	channel_mixer u_mix_right (
		.levels       (levels),
		.chan_mask    (mix_ctrl.right_mask),
		.master       (mix_ctrl.master),
		.volume_shift (volume_shift),
		.sample       (right)
	);

	assign slots = '{cmd: cmd, cmd_data: cmd_data, left: left, right: right};

	frame_serializer u_ser (
		.ac97_bitclk    (ac97_bitclk),
		.rst            (rst),
		.bit_index      (bit_index),
		.frame_start    (frame_start),
		.slots          (slots),
		.ac97_sdata_out (ac97_sdata_out)
	);

	assign ac97_strobe = frame_start; // Frame boundary for the input side

endmodule

//--- verif/ac97_tb_cases.svh
// Columns: name, levels {ch3,ch2,ch1}, ctrl {master,left_mask,right_mask},
// volume_shift, expected left, expected right, random fill flag
typedef struct {
	string                  name;
	ac97_pkg::chan_levels_t levels;
	ac97_pkg::mix_ctrl_t    ctrl;
	logic [3:0]             vol;
	logic [19:0]            exp_left;
	logic [19:0]            exp_right;
	logic                   fill;      // Levels drawn at run start
} mix_case_t;

localparam int n_rows = 10;

mix_case_t cases [n_rows] = '{
	'{"one_ch_each",    12'h395, 7'b1_001_010, 4'd0,  20'd5,      20'd9,      1'b0},
	'{"two_ch_avg",     12'h3a6, 7'b1_011_110, 4'd2,  20'd32,     20'd24,     1'b0},
	'{"silent_ch_skip", 12'h70f, 7'b1_011_111, 4'd1,  20'd30,     20'd20,     1'b0},
	'{"odd_level_half", 12'h0b1, 7'b1_011_100, 4'd4,  20'd80,     20'd0,      1'b0},
	'{"mute_master",    12'hfff, 7'b0_111_111, 4'd3,  20'd0,      20'd0,      1'b0},
	'{"mute_levels",    12'h000, 7'b1_111_111, 4'd5,  20'd0,      20'd0,      1'b0},
	'{"vol_shift_15",   12'hfff, 7'b1_111_101, 4'd15, 20'ha8000,  20'h70000,  1'b0},
	'{"rand_a",         12'h000, 7'b1_101_011, 4'd6,  20'd0,      20'd0,      1'b1},
	'{"rand_b",         12'h000, 7'b1_111_001, 4'd9,  20'd0,      20'd0,      1'b1},
	'{"rand_c",         12'h000, 7'b1_010_110, 4'd12, 20'd0,      20'd0,      1'b1}
};

// Frames 0 to 7 after reset: read flag, register, write data
logic        seq_rd   [8] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
logic [6:0]  seq_addr [8] = '{7'h00, 7'h02, 7'h18, 7'h26, 7'h7c, 7'h7e, 7'h26, 7'h7c};
logic [15:0] seq_data [8] = '{16'h0000, 16'h0000, 16'h0808, 16'h0000,
	16'h0000, 16'h0000, 16'h0000, 16'h0000};

//--- verif/ac97_tb.sv
`timescale 1ns/1ns

module ac97_tb;

	`include "ac97_tb_cases.svh"

	// One whole frame, bit 0 of the frame in the MSB
	typedef struct packed {
		logic [15:0]  tag;
		logic [19:0]  slot1;
		logic [19:0]  slot2;
		logic [19:0]  slot3;
		logic [19:0]  slot4;
		logic [159:0] rest;  // Slots 5 to 12
	} frame_t;

	localparam longint watchdog_ns = longint'(n_rows + 10) * 2 * 256 * 100;
	localparam logic [255:0] sync_pattern   = {15'h7fff, 240'h0, 1'b1}; // Bits 0-14 and 255
	localparam logic [255:0] strobe_pattern = {1'b1, 255'h0};

	logic                   ac97_bitclk;
	logic                   rst;
	ac97_pkg::chan_levels_t levels;
	ac97_pkg::mix_ctrl_t    mix_ctrl;
	logic [3:0]             volume_shift;
	logic                   ac97_sdata_out;
	logic                   ac97_sync;
	logic                   ac97_reset_b;
	logic                   ac97_strobe;

	int checks;       // Within the running test
	int test_errs;
	int tests_run;
	int tests_failed;
	int total_errs;

	ac97_top uut (
		.ac97_bitclk    (ac97_bitclk),
		.rst            (rst),
		.levels         (levels),
		.mix_ctrl       (mix_ctrl),
		.volume_shift   (volume_shift),
		.ac97_sdata_out (ac97_sdata_out),
		.ac97_sync      (ac97_sync),
		.ac97_reset_b   (ac97_reset_b),
		.ac97_strobe    (ac97_strobe)
	);

	always #50 ac97_bitclk = ~ac97_bitclk; // 100 ns period

	task automatic check_value(input string what, input logic [255:0] expected,
			input logic [255:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("[FAIL] %s expected %0h actual %0h", what, expected, actual);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("[PASS] %s", name);
		end else begin
			tests_failed++;
			$display("[FAIL] %s: %0d of %0d checks wrong", name, test_errs, checks);
		end
		test_errs = 0;
		checks    = 0;
	endtask

	// Mixer rule: halve and add for two or more channels, then shift up
	function automatic logic [19:0] expected_sample(input logic [11:0] lv,
			input logic [2:0] mask, input logic master, input logic [3:0] shift);
		int c;
		int level;
		int n_on;
		int last;
		int total;
		n_on  = 0;
		last  = 0;
		total = 0;
		for (c = 0; c < 3; c++) begin
			level = int'((lv >> (4 * c)) & 12'hf);
			if (mask[c] && level != 0) begin
				n_on++;
				last  = level;
				total = total + level / 2;
			end
		end
		if (!master || n_on == 0) begin
			total = 0;
		end else if (n_on == 1) begin
			total = last; // Lone channel goes through whole
		end
		return 20'(total << shift); // Bits above 19 drop
	endfunction

	// Called on a falling edge, samples 1 ns later while outputs hold still
	task automatic capture_frame(output frame_t fr, output logic [255:0] sync_bits,
			output logic [255:0] strobe_bits, output int waited);
		logic [255:0] data;
		int i;
		waited = 0;
		#1;
		while (!ac97_strobe) begin
			@(negedge ac97_bitclk);
			#1;
			waited++;
		end
		for (i = 0; i < 256; i++) begin
			if (i > 0) begin
				@(negedge ac97_bitclk);
				#1;
			end
			data        = {data[254:0], ac97_sdata_out};
			sync_bits   = {sync_bits[254:0], ac97_sync};
			strobe_bits = {strobe_bits[254:0], ac97_strobe};
		end
		fr = data;
	endtask

	task automatic check_frame_shape(input string name, input frame_t fr,
			input logic [255:0] sync_bits, input logic [255:0] strobe_bits);
		check_value({name, " sync"}, sync_pattern, sync_bits);
		check_value({name, " strobe"}, strobe_pattern, strobe_bits);
		check_value({name, " tag"}, 256'(16'hf800), 256'(fr.tag)); // Frame plus slots 1-4
		check_value({name, " slots 5-12"}, 256'(0), 256'(fr.rest));
	endtask

	initial begin
		int unsigned  seed_draw;
		frame_t       fr;
		logic [255:0] sync_bits;
		logic [255:0] strobe_bits;
		int           waited;
		int           f;
		int           r;
		string        name;
		ac97_bitclk  = 1'b0;
		rst          = 1'b1;
		levels       = '0;
		mix_ctrl     = '0;
		volume_shift = 4'd0;
		checks       = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		total_errs   = 0;
		seed_draw    = $urandom(57);
		for (r = 0; r < n_rows; r++) begin
			if (cases[r].fill) begin
				cases[r].levels    = 12'($urandom);
				cases[r].exp_left  = expected_sample(cases[r].levels,
					cases[r].ctrl.left_mask, cases[r].ctrl.master, cases[r].vol);
				cases[r].exp_right = expected_sample(cases[r].levels,
					cases[r].ctrl.right_mask, cases[r].ctrl.master, cases[r].vol);
			end
		end
		@(negedge ac97_bitclk);
		#1;
		check_value("reset_hold reset_b", 256'(0), 256'(ac97_reset_b));
		check_value("reset_hold sync", 256'(0), 256'(ac97_sync));
		check_value("reset_hold sdata", 256'(0), 256'(ac97_sdata_out));
		finish_test("reset_hold");
		@(negedge ac97_bitclk);
		rst = 1'b0; // Two rising edges seen in reset
		// Eight frames back to back, strobe must come right away each time
		for (f = 0; f < 8; f++) begin
			if (f > 0) begin
				@(negedge ac97_bitclk);
			end
			capture_frame(fr, sync_bits, strobe_bits, waited);
			name = $sformatf("cmd_frame_%0d", f);
			check_value({name, " strobe gap"}, 256'(0), 256'(waited));
			check_frame_shape(name, fr, sync_bits, strobe_bits);
			check_value({name, " slot1"}, 256'({seq_rd[f], seq_addr[f], 12'h000}),
				256'(fr.slot1));
			check_value({name, " slot2"}, 256'({seq_data[f], 4'h0}), 256'(fr.slot2));
			check_value({name, " slot3"}, 256'(0), 256'(fr.slot3)); // Inputs all zero
			check_value({name, " slot4"}, 256'(0), 256'(fr.slot4));
			check_value({name, " reset_b"}, 256'(1), 256'(ac97_reset_b));
			finish_test(name);
		end
		for (r = 0; r < n_rows; r++) begin
			repeat (128) @(negedge ac97_bitclk); // Middle of a frame
			levels       = cases[r].levels;
			mix_ctrl     = cases[r].ctrl;
			volume_shift = cases[r].vol;
			capture_frame(fr, sync_bits, strobe_bits, waited);
			name = cases[r].name;
			check_frame_shape(name, fr, sync_bits, strobe_bits);
			check_value({name, " left"}, 256'(cases[r].exp_left), 256'(fr.slot3));
			check_value({name, " right"}, 256'(cases[r].exp_right), 256'(fr.slot4));
			finish_test(name);
		end
		$display("Tests run %0d, passed %0d, failed %0d, wrong checks %0d",
			tests_run, tests_run - tests_failed, tests_failed, total_errs);
		if (total_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Two frames per table row plus margin for the command frames
	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- ac97_link.f
+incdir+verif
src/ac97_pkg.sv
src/link_bit_counter.sv
src/codec_init_fsm.sv
src/channel_mixer.sv
src/frame_serializer.sv
src/ac97_top.sv
verif/ac97_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module ac97_tb -f ac97_link.f &&
sim_out="$(./obj_dir/Vac97_tb)" &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -q "TEST PASSED" ||
{ echo "Simulation did not pass"; exit 1; }
